//--- mem_sub.f
+incdir+include
rtl/mem_sub_pkg.sv
rtl/byte_ram.sv
rtl/mem_ctrl.sv
rtl/fetch_unit.sv
rtl/lsu_queue.sv
rtl/mem_sub_top.sv
bench/mem_sub_tb.sv

//--- Makefile
# Verilator build and run of the mem_sub testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f mem_sub.f \
		--top-module mem_sub_tb -o mem_sub_sim
	./obj_dir/mem_sub_sim

clean:
	rm -rf obj_dir

//--- bench/mem_sub_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sub_cfg.svh"

module mem_sub_tb;

    localparam int AW        = `MEM_SUB_ADDR_W;
    localparam int RAM_SIZE  = 1 << AW;
    localparam int N_FILL    = RAM_SIZE / 4;
    localparam int N_MIX     = 400;
    localparam int LIMIT     = 20 * (N_FILL + N_MIX + 16) + 2000;
    localparam int DRAIN_MAX = 20 * (`MEM_SUB_LSQ_DEPTH + 2);

    logic                   clk_in;
    logic                   arst_n;
    logic                   rdy;
    logic                   flush;
    logic [31:0]            redirect_pc;
    logic                   fetch_en;
    logic                   req_push;
    mem_sub_pkg::acc_kind_e req_kind;
    mem_sub_pkg::width_e    req_width;
    logic [31:0]            req_addr;
    logic [31:0]            req_data;
    wire                    req_full;
    wire                    load_valid;
    wire [31:0]             load_data;
    wire                    inst_valid;
    wire [31:0]             inst;
    wire [31:0]             inst_pc;

    logic [7:0]  model [RAM_SIZE];   // mirrors stores at push time
    logic [31:0] exp_q [$];          // expected load results, push order
    logic [31:0] exp_pc;
    logic [31:0] rng;
    int          n_ld_push;
    int          n_ld_done;
    int          cycles;
    bit          stall_on;
    bit          fetch_on;

    mem_sub_top DUT (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .rdy         (rdy),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .fetch_en    (fetch_en),
        .req_push    (req_push),
        .req_kind    (req_kind),
        .req_width   (req_width),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .req_full    (req_full),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic mem_sub_pkg::width_e pick_width(input logic [31:0] r);
        case (r % 5)
            0:       return mem_sub_pkg::W_BYTE;
            1:       return mem_sub_pkg::W_HALF;
            2:       return mem_sub_pkg::W_WORD;
            3:       return mem_sub_pkg::W_BYTE_U;
            default: return mem_sub_pkg::W_HALF_U;
        endcase
    endfunction

    function automatic int width_bytes(input mem_sub_pkg::width_e w);
        if (w == mem_sub_pkg::W_WORD) return 4;
        if (w == mem_sub_pkg::W_HALF || w == mem_sub_pkg::W_HALF_U) return 2;
        return 1;
    endfunction

    // little-endian read of the model with sign or zero extension
    function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                                input mem_sub_pkg::width_e w);
        logic [AW-1:0] a;
        logic [7:0]    b0;
        logic [7:0]    b1;
        a  = addr[AW-1:0];
        b0 = model[a];
        b1 = model[a + AW'(1)];
        case (w)
            mem_sub_pkg::W_BYTE:   return {{24{b0[7]}}, b0};
            mem_sub_pkg::W_HALF:   return {{16{b1[7]}}, b1, b0};
            mem_sub_pkg::W_BYTE_U: return {24'd0, b0};
            mem_sub_pkg::W_HALF_U: return {16'd0, b1, b0};
            default:               return {model[a + AW'(3)], model[a + AW'(2)], b1, b0};
        endcase
    endfunction

    task automatic end_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic plain_failure(input string msg);
        $display("%0t: %s", $time, msg);
        end_with_failure();
    endtask

    // one falling edge, inputs back to quiet, random stall if enabled
    task automatic next_cycle();
        @(negedge clk_in);
        req_push = 1'b0;
        flush    = 1'b0;
        rdy      = stall_on ? (rand32() % 4 != 0) : 1'b1;
        fetch_en = fetch_on && exp_pc[AW-1:0] < AW'('h700)
                && (rand32() & 32'hf) != 32'd0;
    endtask

    task automatic push_req(input mem_sub_pkg::acc_kind_e kind, input mem_sub_pkg::width_e w,
                            input logic [31:0] addr, input logic [31:0] data);
        next_cycle();
        // outstanding loads all still hold a queue entry
        assert (exp_q.size() < `MEM_SUB_LSQ_DEPTH || req_full)
            else plain_failure("req_full is low while the queue is full of loads");
        while (!rdy || req_full) begin
            next_cycle();
        end
        req_push  = 1'b1;
        req_kind  = kind;
        req_width = w;
        req_addr  = addr;
        req_data  = data;
        if (kind == mem_sub_pkg::ACC_STORE) begin
            for (int k = 0; k < width_bytes(w); k++) begin
                model[addr[AW-1:0] + AW'(k)] = data[8*k +: 8];
            end
        end else begin
            exp_q.push_back(expect_load(addr, w));
            n_ld_push++;
        end
    endtask

    task automatic drain_loads();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_MAX) begin
            next_cycle();
            waited++;
        end
        assert (n_ld_push == n_ld_done)
            else mismatch($sformatf("%0d load results for %0d loads", n_ld_done, n_ld_push));
    endtask

    always @(posedge clk_in) begin
        if (arst_n) begin
            assert (rdy || !(load_valid || inst_valid))
                else plain_failure("result pulse while rdy was low");
            if (load_valid) begin
                assert (exp_q.size() != 0)
                    else plain_failure("load result with no outstanding load");
                assert (load_data == exp_q[0])
                    else mismatch($sformatf("load got %h expected %h", load_data, exp_q[0]));
                void'(exp_q.pop_front());
                n_ld_done++;
            end
            if (inst_valid) begin
                assert (inst_pc == exp_pc)
                    else mismatch($sformatf("inst_pc %h expected %h", inst_pc, exp_pc));
                assert (inst == expect_load(inst_pc, mem_sub_pkg::W_WORD))
                    else mismatch($sformatf("inst %h at pc %h", inst, inst_pc));
                exp_pc = exp_pc + 32'd4;
            end
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            end_with_failure();
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        rng = 32'h69b5_864f;
        arst_n = 1'b0;
        rdy = 1'b1;
        flush = 1'b0;
        redirect_pc = 32'd0;
        fetch_en = 1'b0;
        req_push = 1'b0;
        req_kind = mem_sub_pkg::ACC_LOAD;
        req_width = mem_sub_pkg::W_WORD;
        req_addr = 32'd0;
        req_data = 32'd0;
        exp_pc = `MEM_SUB_RESET_PC;
        n_ld_push = 0;
        n_ld_done = 0;
        cycles = 0;
        stall_on = 1'b0;
        fetch_on = 1'b0;
        repeat (2) @(negedge clk_in);
        arst_n = 1'b1;

        // whole ram, pattern hashed from the full address
        for (int i = 0; i < N_FILL; i++) begin
            push_req(mem_sub_pkg::ACC_STORE, mem_sub_pkg::W_WORD, 32'(i * 4),
                     xorshift(32'(i * 4) ^ 32'hc3a5_0f1e));
        end

        // mixed traffic, stores kept above 0x800 away from the fetch stream
        stall_on = 1'b1;
        fetch_on = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            repeat (rand32() % 8) next_cycle();   // idle gaps let fetches in
            r = rand32();
            a = 32'h800 | (rand32() & 32'h7f8) | 32'(r[9:8]);
            if (r[0]) begin
                push_req(mem_sub_pkg::ACC_STORE, pick_width(r >> 2), a, rand32());
            end else begin
                push_req(mem_sub_pkg::ACC_LOAD, pick_width(r >> 2), r[1] ? a : a & 32'h7ff,
                         32'd0);
            end
        end
        drain_loads();

        // quiet the fetch side so the next store goes straight into flight
        stall_on = 1'b0;
        fetch_on = 1'b0;
        repeat (`MEM_SUB_LSQ_DEPTH + 1) begin
            push_req(mem_sub_pkg::ACC_LOAD, mem_sub_pkg::W_WORD, 32'h800, 32'd0);
        end
        drain_loads();
        repeat (8) next_cycle();

        a = 32'h900 | (rand32() & 32'h0fc);
        d = rand32();
        push_req(mem_sub_pkg::ACC_STORE, mem_sub_pkg::W_WORD, a, d);
        push_req(mem_sub_pkg::ACC_LOAD, mem_sub_pkg::W_HALF, a, 32'd0);
        next_cycle();
        flush       = 1'b1;   // store now in flight, load still queued
        redirect_pc = rand32() & 32'h3fc;
        exp_q.delete();
        n_ld_push = n_ld_done;   // flushed loads never complete
        exp_pc   = redirect_pc;
        fetch_on = 1'b1;
        while (exp_pc == redirect_pc) begin
            next_cycle();
        end
        fetch_on = 1'b0;
        push_req(mem_sub_pkg::ACC_LOAD, mem_sub_pkg::W_WORD, a, 32'd0);
        drain_loads();
        repeat (8) next_cycle();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/mem_sub_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sub_cfg.svh"

module mem_sub_top (
    input  wire                         clk_in,
    input  wire                         arst_n,
    input  wire                         rdy,
    input  wire                         flush,
    input  wire [31:0]                  redirect_pc,
    input  wire                         fetch_en,
    input  wire                         req_push,
    input  wire mem_sub_pkg::acc_kind_e req_kind,
    input  wire mem_sub_pkg::width_e    req_width,
    input  wire [31:0]                  req_addr,
    input  wire [31:0]                  req_data,
    output wire                         req_full,
    output wire                         load_valid,
    output wire [31:0]                  load_data,
    output wire                         inst_valid,
    output wire [31:0]                  inst,
    output wire [31:0]                  inst_pc
);

    wire                         fetch_req;
    wire [31:0]                  fetch_pc;
    wire                         fetch_done;
    wire [31:0]                  fetch_word;
    wire                         lsu_req;
    wire mem_sub_pkg::acc_kind_e lsu_kind;
    wire mem_sub_pkg::width_e    lsu_width;
    wire [31:0]                  lsu_addr;
    wire [31:0]                  lsu_wdata;
    wire                         lsu_done;
    wire [31:0]                  lsu_rdata;
    wire                         ram_we;
    wire [`MEM_SUB_ADDR_W-1:0]   ram_addr;
    wire [7:0]                   ram_wdata;
    wire [7:0]                   ram_rdata;

    // head entry is the one completing
    assign load_valid = lsu_done && lsu_kind == mem_sub_pkg::ACC_LOAD;
    assign load_data  = lsu_rdata;

    mem_ctrl u_mem_ctrl (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .rdy        (rdy),
        .flush      (flush),
        .fetch_req  (fetch_req),
        .fetch_pc   (fetch_pc),
        .lsu_req    (lsu_req),
        .lsu_kind   (lsu_kind),
        .lsu_width  (lsu_width),
        .lsu_addr   (lsu_addr),
        .lsu_wdata  (lsu_wdata),
        .ram_rdata  (ram_rdata),
        .fetch_done (fetch_done),
        .fetch_word (fetch_word),
        .lsu_done   (lsu_done),
        .lsu_rdata  (lsu_rdata),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata)
    );

    fetch_unit u_fetch_unit (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .rdy         (rdy),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .fetch_en    (fetch_en),
        .fetch_done  (fetch_done),
        .fetch_word  (fetch_word),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc)
    );

    lsu_queue u_lsu_queue (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .rdy       (rdy),
        .flush     (flush),
        .req_push  (req_push),
        .req_kind  (req_kind),
        .req_width (req_width),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .lsu_done  (lsu_done),
        .req_full  (req_full),
        .lsu_req   (lsu_req),
        .lsu_kind  (lsu_kind),
        .lsu_width (lsu_width),
        .lsu_addr  (lsu_addr),
        .lsu_wdata (lsu_wdata)
    );

    byte_ram u_byte_ram (
        .clk_in    (clk_in),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/lsu_queue.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sub_cfg.svh"

module lsu_queue (
    input  wire                          clk_in,
    input  wire                          arst_n,
    input  wire                          rdy,
    input  wire                          flush,
    input  wire                          req_push,
    input  wire mem_sub_pkg::acc_kind_e  req_kind,
    input  wire mem_sub_pkg::width_e     req_width,
    input  wire [31:0]                   req_addr,
    input  wire [31:0]                   req_data,
    input  wire                          lsu_done,
    output logic                         req_full,
    output logic                         lsu_req,
    output mem_sub_pkg::acc_kind_e       lsu_kind,
    output mem_sub_pkg::width_e          lsu_width,
    output logic [31:0]                  lsu_addr,
    output logic [31:0]                  lsu_wdata
);

    localparam int DEPTH = `MEM_SUB_LSQ_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    mem_sub_pkg::acc_kind_e kind_mem  [DEPTH];
    mem_sub_pkg::width_e    width_mem [DEPTH];
    logic [31:0]            addr_mem  [DEPTH];
    logic [31:0]            data_mem  [DEPTH];

    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW:0]   count;
    logic          push;
    logic          pop;

    assign push = rdy && req_push && !req_full;
    assign pop  = lsu_done;   // already qualified by rdy

    assign req_full  = count == (PW+1)'(DEPTH);
    assign lsu_req   = count != '0;
    assign lsu_kind  = kind_mem[rd_ptr];
    assign lsu_width = width_mem[rd_ptr];
    assign lsu_addr  = addr_mem[rd_ptr];
    assign lsu_wdata = data_mem[rd_ptr];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) begin
            kind_mem[wr_ptr]  <= req_kind;
            width_mem[wr_ptr] <= req_width;
            addr_mem[wr_ptr]  <= req_addr;
            data_mem[wr_ptr]  <= req_data;
        end
    end

    a_no_push_full : assert property (@(posedge clk_in) disable iff (!arst_n)
        (rdy && req_push) |-> !req_full);

    // the controller only completes an access that still has its entry here
    a_done_has_head : assert property (@(posedge clk_in) disable iff (!arst_n)
        lsu_done |-> lsu_req);

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sub_cfg.svh"

module fetch_unit (
    input  wire         clk_in,
    input  wire         arst_n,
    input  wire         rdy,
    input  wire         flush,
    input  wire [31:0]  redirect_pc,
    input  wire         fetch_en,
    input  wire         fetch_done,
    input  wire [31:0]  fetch_word,
    output logic        fetch_req,
    output logic [31:0] fetch_pc,
    output logic        inst_valid,
    output logic [31:0] inst,
    output logic [31:0] inst_pc
);

    logic [31:0] pc_q;
    logic        hold_q;    // request stays up until served
    logic        valid_q;

    assign fetch_req  = fetch_en || hold_q;
    assign fetch_pc   = pc_q;
    assign inst_valid = valid_q && rdy && !flush;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            pc_q    <= `MEM_SUB_RESET_PC;
            hold_q  <= 1'b0;
            valid_q <= 1'b0;
        end else if (flush) begin
            pc_q    <= redirect_pc;
            hold_q  <= 1'b0;
            valid_q <= 1'b0;   // drop a word not yet shown
        end else if (rdy) begin
            hold_q  <= fetch_req && !fetch_done;
            valid_q <= fetch_done;
            if (fetch_done) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (fetch_done) begin
            inst    <= fetch_word;
            inst_pc <= pc_q;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sub_cfg.svh"

module mem_ctrl (
    input  wire                         clk_in,
    input  wire                         arst_n,
    input  wire                         rdy,
    input  wire                         flush,
    input  wire                         fetch_req,
    input  wire [31:0]                  fetch_pc,
    input  wire                         lsu_req,
    input  wire mem_sub_pkg::acc_kind_e lsu_kind,
    input  wire mem_sub_pkg::width_e    lsu_width,
    input  wire [31:0]                  lsu_addr,
    input  wire [31:0]                  lsu_wdata,
    input  wire [7:0]                   ram_rdata,
    output logic                        fetch_done,
    output logic [31:0]                 fetch_word,
    output logic                        lsu_done,
    output logic [31:0]                 lsu_rdata,
    output logic                        ram_we,
    output logic [`MEM_SUB_ADDR_W-1:0]  ram_addr,
    output logic [7:0]                  ram_wdata
);

    localparam int AW = `MEM_SUB_ADDR_W;

    mem_sub_pkg::owner_e    owner_q;
    mem_sub_pkg::acc_kind_e kind_q;
    mem_sub_pkg::width_e    width_q;
    logic [AW-1:0]          addr_q;     // byte 0 address
    logic [2:0]             rem_q;      // bytes left after the current one
    logic [31:0]            wdata_q;
    logic [23:0]            load_q;     // bytes 0..2 of a load or fetch
    logic                   orphan_q;   // store whose queue entry was flushed

    logic       busy;
    logic       store_busy;
    logic       abort;
    logic       start_lsu;
    logic       start_fetch;
    logic       last_byte;
    logic [2:0] idx;
    logic [2:0] nxt_off;

    function automatic logic [2:0] byte_cnt_m1(input mem_sub_pkg::width_e w);
        case (w[1:0])
            2'b00:   return 3'd0;
            2'b01:   return 3'd1;
            default: return 3'd3;
        endcase
    endfunction

    function automatic logic [31:0] extend(input mem_sub_pkg::width_e w,
                                           input logic [23:0] part,
                                           input logic [7:0] top);
        case (w)
            mem_sub_pkg::W_BYTE:   return {{24{top[7]}}, top};
            mem_sub_pkg::W_HALF:   return {{16{top[7]}}, top, part[7:0]};
            mem_sub_pkg::W_BYTE_U: return {24'd0, top};
            mem_sub_pkg::W_HALF_U: return {16'd0, top, part[7:0]};
            default:               return {top, part};
        endcase
    endfunction

    assign busy        = owner_q != mem_sub_pkg::OWN_NONE;
    assign store_busy  = owner_q == mem_sub_pkg::OWN_LSU && kind_q == mem_sub_pkg::ACC_STORE;
    assign abort       = flush && !store_busy;   // stores always run to the end
    assign start_lsu   = rdy && !flush && !busy && lsu_req;
    assign start_fetch = rdy && !flush && !busy && !lsu_req && fetch_req;
    assign last_byte   = busy && rem_q == 3'd0;
    assign idx         = byte_cnt_m1(width_q) - rem_q;   // byte whose data is on ram_rdata
    assign nxt_off     = idx + 3'd1;

    // While stalled the address of the byte being received is put back on the
    // port, so the registered read still returns that byte when rdy comes back.
    always_comb begin
        if (busy) begin
            ram_addr = addr_q + AW'(rdy ? nxt_off : idx);
        end else if (lsu_req) begin
            ram_addr = lsu_addr[AW-1:0];
        end else begin
            ram_addr = fetch_pc[AW-1:0];
        end
    end

    always_comb begin
        if (!busy) begin
            ram_wdata = lsu_wdata[7:0];   // byte 0 at issue
        end else begin
            case (nxt_off)
                3'd1:    ram_wdata = wdata_q[15:8];
                3'd2:    ram_wdata = wdata_q[23:16];
                3'd3:    ram_wdata = wdata_q[31:24];
                default: ram_wdata = wdata_q[7:0];
            endcase
        end
    end

    assign ram_we = (start_lsu && lsu_kind == mem_sub_pkg::ACC_STORE)
                 || (rdy && store_busy && rem_q != 3'd0);

    assign fetch_done = rdy && !flush && last_byte && owner_q == mem_sub_pkg::OWN_FETCH;
    assign lsu_done   = rdy && last_byte && owner_q == mem_sub_pkg::OWN_LSU
                     && (store_busy ? !orphan_q : !flush);
    assign fetch_word = {ram_rdata, load_q};   // last byte taken live
    assign lsu_rdata  = extend(width_q, load_q, ram_rdata);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            owner_q  <= mem_sub_pkg::OWN_NONE;
            rem_q    <= 3'd0;
            orphan_q <= 1'b0;
        end else if (abort) begin
            owner_q <= mem_sub_pkg::OWN_NONE;
            rem_q   <= 3'd0;
        end else begin
            if (flush) begin
                orphan_q <= 1'b1;   // only reached with a store in flight
            end
            if (start_lsu) begin
                owner_q <= mem_sub_pkg::OWN_LSU;
                rem_q   <= byte_cnt_m1(lsu_width);
            end else if (start_fetch) begin
                owner_q <= mem_sub_pkg::OWN_FETCH;
                rem_q   <= 3'd3;
            end else if (rdy && busy) begin
                if (rem_q == 3'd0) begin
                    owner_q  <= mem_sub_pkg::OWN_NONE;
                    orphan_q <= 1'b0;
                end else begin
                    rem_q <= rem_q - 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start_lsu) begin
            kind_q  <= lsu_kind;
            width_q <= lsu_width;
            addr_q  <= lsu_addr[AW-1:0];
            wdata_q <= lsu_wdata;
        end else if (start_fetch) begin
            kind_q  <= mem_sub_pkg::ACC_LOAD;
            width_q <= mem_sub_pkg::W_WORD;
            addr_q  <= fetch_pc[AW-1:0];
        end
        if (rdy && busy && rem_q != 3'd0) begin
            case (idx)
                3'd0:    load_q[7:0]   <= ram_rdata;
                3'd1:    load_q[15:8]  <= ram_rdata;
                3'd2:    load_q[23:16] <= ram_rdata;
                default: load_q        <= load_q;
            endcase
        end
    end

    // fetch sequences never write the ram
    a_no_fetch_write : assert property (@(posedge clk_in) disable iff (!arst_n)
        ram_we |-> owner_q != mem_sub_pkg::OWN_FETCH);

    a_rem_range : assert property (@(posedge clk_in) disable iff (!arst_n)
        busy |-> (rem_q <= 3'd3 && rem_q <= byte_cnt_m1(width_q)));

endmodule

`default_nettype wire

//--- rtl/byte_ram.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sub_cfg.svh"

module byte_ram (
    input  wire                        clk_in,
    input  wire                        ram_we,
    input  wire [`MEM_SUB_ADDR_W-1:0]  ram_addr,
    input  wire [7:0]                  ram_wdata,
    output logic [7:0]                 ram_rdata
);

    localparam int WORDS = 1 << `MEM_SUB_ADDR_W;

    logic [7:0] mem [WORDS];

    always_ff @(posedge clk_in) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
        ram_rdata <= mem[ram_addr];   // old data on a same-cycle write
    end

endmodule

`default_nettype wire

//--- rtl/mem_sub_pkg.sv
`default_nettype none

package mem_sub_pkg;

    // client holding the ram port
    typedef enum logic [1:0] {
        OWN_NONE  = 2'd0,
        OWN_FETCH = 2'd1,
        OWN_LSU   = 2'd2
    } owner_e;

    typedef enum logic {
        ACC_LOAD  = 1'b0,
        ACC_STORE = 1'b1
    } acc_kind_e;

    // funct3 coding, low two bits give log2 of the byte count
    typedef enum logic [2:0] {
        W_BYTE   = 3'b000,
        W_HALF   = 3'b001,
        W_WORD   = 3'b010,
        W_BYTE_U = 3'b100,
        W_HALF_U = 3'b101
    } width_e;

endpackage

`default_nettype wire

//--- include/mem_sub_cfg.svh
`ifndef MEM_SUB_CFG_SVH
`define MEM_SUB_CFG_SVH

// ram address bits, 4 KiB of bytes
`define MEM_SUB_ADDR_W 12

// load/store queue entries, power of two
`define MEM_SUB_LSQ_DEPTH 4

// first fetch address out of reset
`define MEM_SUB_RESET_PC 32'h0000_0000

`endif
